/* policer_pkg.sv */
/* Policer package with stream widths, fixed-point bucket types,
   stream beat and config structs, and the table select enum */
package policer_pkg;

    ////////////////////////////////////////
    // Widths

    // Stream data width in bytes
    localparam int DATA_BYTES = 8;
    // Ingress port field, up to 16 ports
    localparam int PORT_ID_BITS = 4;
    // Fixed-point layout of bucket and rate
    localparam int FRAC_BITS = 16;
    localparam int WHOLE_BITS = 20;
    localparam int BUCKET_BITS = WHOLE_BITS + FRAC_BITS;

    // Config access fields
    // Index is wider than the port field so bad indices can be seen
    localparam int CFG_INDEX_BITS = 6;
    localparam int CFG_DATA_BITS = BUCKET_BITS;

    ////////////////////////////////////////
    // Bucket types

    typedef logic [15:0] byte_len_t;

    // Bucket level in bytes, whole part above fraction
    typedef struct packed {
        logic [WHOLE_BITS-1:0] whole;
        logic [FRAC_BITS-1:0]  fraction;
    } bucket_t;

    // Drain per clock in bytes
    typedef bucket_t rate_t;

    // Threshold in whole bytes
    typedef logic [WHOLE_BITS-1:0] depth_t;

    ////////////////////////////////////////
    // Stream beat

    typedef struct packed {
        logic [PORT_ID_BITS-1:0] ingress_port;
        byte_len_t               byte_length;
        logic                    drop_mark;
    } pkt_meta_t;

    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
        pkt_meta_t               meta;
    } pkt_beat_t;

    ////////////////////////////////////////
    // Config access

    typedef enum logic {
        table_cir = 1'b0,
        table_cbs = 1'b1
    } policer_table_e;

    typedef struct packed {
        logic                      write;
        policer_table_e            table_sel;
        logic [CFG_INDEX_BITS-1:0] port;
        logic [CFG_DATA_BITS-1:0]  wdata;
    } cfg_req_t;

    typedef struct packed {
        logic [CFG_DATA_BITS-1:0] rdata;
        logic                     error;
    } cfg_rsp_t;

endpackage

/* policer_config.sv */
/* CIR and CBS tables, one entry per ingress port, behind a
   four-phase req/ack access port with an out-of-range error */
module policer_config
    import policer_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic     packet_in,
    input  logic     arst_n,
    input  logic     cfg_req_valid,
    input  cfg_req_t cfg_req,
    output logic     cfg_ack,
    output cfg_rsp_t cfg_rsp,
    output rate_t    rate  [NUM_PORTS],
    output depth_t   depth [NUM_PORTS]
);

    // Table index width, at least one bit
    localparam int IDX_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic                     req_new;
    logic                     in_range;
    logic [IDX_BITS-1:0]      idx;
    logic [CFG_DATA_BITS-1:0] rd_data;

    ////////////////////////////////////////
    // Request decode

    // New request only while ack is low
    assign req_new  = cfg_req_valid && !cfg_ack;
    assign in_range = cfg_req.port < NUM_PORTS;
    // Index only meaningful when in range
    assign idx      = cfg_req.port[IDX_BITS-1:0];

    // Read mux
    // Depth is zero-extended to the data width
    always_comb begin
        rd_data = '0;
        if (in_range) begin
            case (cfg_req.table_sel)
                table_cir: rd_data = rate[idx];
                table_cbs: rd_data = CFG_DATA_BITS'(depth[idx]);
                default:   rd_data = '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // Handshake and table write

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            cfg_ack <= 1'b0;
            // Tables come up fully open
            rate    <= '{default: '1};
            depth   <= '{default: '1};
        end else begin
            if (req_new) begin
                // Ack and write land on the same edge
                cfg_ack <= 1'b1;
                if (cfg_req.write && in_range) begin
                    case (cfg_req.table_sel)
                        table_cir: rate[idx]  <= cfg_req.wdata;
                        table_cbs: depth[idx] <= cfg_req.wdata[WHOLE_BITS-1:0];
                        default:   ;
                    endcase
                end
            end else if (!cfg_req_valid) begin
                // Requester has let go, close the cycle
                cfg_ack <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Response

    // Captured with the ack, held until the next request
    always_ff @(posedge packet_in) begin
        if (req_new) begin
            // Writes return zero data
            cfg_rsp.rdata <= cfg_req.write ? '0 : rd_data;
            // Bad index reports error, data already zero
            cfg_rsp.error <= !in_range;
        end
    end

endmodule

/* bucket_array.sv */
/* Per-port leaky bucket accumulators with drain and fill,
   and the combinational drop decision for a packet head */
module bucket_array
    import policer_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                    packet_in,
    input  logic                    arst_n,
    input  logic [NUM_PORTS-1:0]    enable,
    input  rate_t                   rate  [NUM_PORTS],
    input  depth_t                  depth [NUM_PORTS],
    input  logic                    head_valid,
    input  logic [PORT_ID_BITS-1:0] head_port,
    input  byte_len_t               head_length,
    output logic                    drop_mark
);

    localparam int IDX_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    bucket_t             bucket [NUM_PORTS];
    logic                head_known;
    logic [IDX_BITS-1:0] head_idx;
    logic [WHOLE_BITS:0] head_fill;
    logic                head_over;

    ////////////////////////////////////////
    // Drop decision

    // Heads on ports past the array are never policed
    assign head_known = head_port < NUM_PORTS;
    assign head_idx   = head_port[IDX_BITS-1:0];

    // Whole-byte fill the head would reach
    // One extra bit keeps the carry
    assign head_fill = {1'b0, bucket[head_idx].whole} + (WHOLE_BITS + 1)'(head_length);
    assign head_over = head_fill > (WHOLE_BITS + 1)'(depth[head_idx]);

    // Disabled ports never mark
    assign drop_mark = head_valid && head_known && enable[head_idx] && head_over;

    ////////////////////////////////////////
    // Bucket update

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_bucket
        logic                 admit;
        logic [BUCKET_BITS:0] fill;
        logic [BUCKET_BITS:0] level;

        // Admitted head for this port
        assign admit = head_valid && head_known && (head_idx == p) && enable[p] && !head_over;

        // Length moves into the whole part
        assign fill = admit ? (BUCKET_BITS + 1)'({head_length, {FRAC_BITS{1'b0}}}) : '0;

        // Level before the drain
        // Admission keeps it under the depth, so the top bit stays clear
        assign level = {1'b0, bucket[p]} + fill;

        always_ff @(posedge packet_in or negedge arst_n) begin
            if (!arst_n) begin
                bucket[p] <= '0;
            end else if (!enable[p] || level <= {1'b0, rate[p]}) begin
                // Drains to empty, no wrap below zero
                bucket[p] <= '0;
            end else begin
                bucket[p] <= level[BUCKET_BITS-1:0] - rate[p];
            end
        end
    end

endmodule

/* policer_stage.sv */
/* Single register stage on the packet stream with stall,
   packet-head tracking and drop-mark merge into metadata */
module policer_stage
    import policer_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                 packet_in,
    input  logic                 arst_n,
    input  logic [NUM_PORTS-1:0] enable,
    input  rate_t                rate  [NUM_PORTS],
    input  depth_t               depth [NUM_PORTS],
    input  logic                 pkt_rx_valid,
    input  pkt_beat_t            pkt_rx_data,
    output logic                 pkt_rx_ready,
    output logic                 pkt_tx_valid,
    output pkt_beat_t            pkt_tx_data,
    input  logic                 pkt_tx_ready
);

    logic      rx_fire;
    logic      at_head;
    logic      head_valid;
    logic      head_drop;
    logic      held_drop;
    logic      beat_drop;
    pkt_beat_t beat_marked;

    ////////////////////////////////////////
    // Handshake

    // Accept when the output slot is free or drains this cycle
    assign pkt_rx_ready = !pkt_tx_valid || pkt_tx_ready;
    assign rx_fire      = pkt_rx_valid && pkt_rx_ready;
    assign head_valid   = rx_fire && at_head;

    ////////////////////////////////////////
    // Policing

    bucket_array #(
        .NUM_PORTS (NUM_PORTS)
    ) bucket_array_i (
        .packet_in   (packet_in),
        .arst_n      (arst_n),
        .enable      (enable),
        .rate        (rate),
        .depth       (depth),
        .head_valid  (head_valid),
        .head_port   (pkt_rx_data.meta.ingress_port),
        .head_length (pkt_rx_data.meta.byte_length),
        .drop_mark   (head_drop)
    );

    // Head takes the fresh decision, body beats the held one
    assign beat_drop = at_head ? head_drop : held_drop;

    // Merge with any mark set upstream
    always_comb begin
        beat_marked = pkt_rx_data;
        beat_marked.meta.drop_mark = pkt_rx_data.meta.drop_mark | beat_drop;
    end

    ////////////////////////////////////////
    // Control

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            at_head      <= 1'b1;
            held_drop    <= 1'b0;
            pkt_tx_valid <= 1'b0;
        end else begin
            if (rx_fire) begin
                // Next beat opens a packet after a last
                at_head      <= pkt_rx_data.last;
                pkt_tx_valid <= 1'b1;
            end else if (pkt_tx_ready) begin
                pkt_tx_valid <= 1'b0;
            end
            if (head_valid) begin
                held_drop <= head_drop;
            end
        end
    end

    // Output beat, held under back-pressure
    always_ff @(posedge packet_in) begin
        if (rx_fire) begin
            pkt_tx_data <= beat_marked;
        end
    end

endmodule

/* ingress_policer_top.sv */
/* Ingress policer top level
   Joins the CIR/CBS config table and the policer stream stage */
module ingress_policer_top
    import policer_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                 packet_in,
    input  logic                 arst_n,
    input  logic [NUM_PORTS-1:0] enable,
    input  logic                 pkt_rx_valid,
    input  pkt_beat_t            pkt_rx_data,
    output logic                 pkt_rx_ready,
    output logic                 pkt_tx_valid,
    output pkt_beat_t            pkt_tx_data,
    input  logic                 pkt_tx_ready,
    input  logic                 cfg_req_valid,
    input  cfg_req_t             cfg_req,
    output logic                 cfg_ack,
    output cfg_rsp_t             cfg_rsp
);

    // Table outputs feeding the buckets
    rate_t  rate  [NUM_PORTS];
    depth_t depth [NUM_PORTS];

    ////////////////////////////////////////
    // Config table

    policer_config #(
        .NUM_PORTS (NUM_PORTS)
    ) policer_config_i (
        .packet_in     (packet_in),
        .arst_n        (arst_n),
        .cfg_req_valid (cfg_req_valid),
        .cfg_req       (cfg_req),
        .cfg_ack       (cfg_ack),
        .cfg_rsp       (cfg_rsp),
        .rate          (rate),
        .depth         (depth)
    );

    ////////////////////////////////////////
    // Stream stage

    policer_stage #(
        .NUM_PORTS (NUM_PORTS)
    ) policer_stage_i (
        .packet_in    (packet_in),
        .arst_n       (arst_n),
        .enable       (enable),
        .rate         (rate),
        .depth        (depth),
        .pkt_rx_valid (pkt_rx_valid),
        .pkt_rx_data  (pkt_rx_data),
        .pkt_rx_ready (pkt_rx_ready),
        .pkt_tx_valid (pkt_tx_valid),
        .pkt_tx_data  (pkt_tx_data),
        .pkt_tx_ready (pkt_tx_ready)
    );

endmodule

/* ingress_policer_assertions.sv */
/* Bound checks on the config handshake, output hold under
   back-pressure and the idle state out of reset */
module ingress_policer_assertions
    import policer_pkg::*;
(
    input logic      packet_in,
    input logic      arst_n,
    input logic      cfg_req_valid,
    input logic      cfg_ack,
    input logic      pkt_tx_valid,
    input logic      pkt_tx_ready,
    input pkt_beat_t pkt_tx_data
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////
    // Config handshake

    // Ack may only fall once the request is gone
    ack_hold_a: assert property (
        @(posedge packet_in) disable iff (!arst_n)
        cfg_ack && cfg_req_valid |=> cfg_ack
    ) else $error("cfg_ack fell while cfg_req_valid was still high");

    ////////////////////////////////////////
    // Stream output

    // Stalled beat stays put
    tx_hold_a: assert property (
        @(posedge packet_in) disable iff (!arst_n)
        pkt_tx_valid && !pkt_tx_ready |=> pkt_tx_valid && $stable(pkt_tx_data)
    ) else $error("pkt_tx beat changed or vanished under back-pressure");

    // Still idle after the first edge out of reset
    reset_idle_a: assert property (
        @(posedge packet_in)
        $rose(arst_n) |=> !pkt_tx_valid && !cfg_ack
    ) else $error("pkt_tx_valid or cfg_ack high right after reset");

endmodule

bind ingress_policer_top ingress_policer_assertions ingress_policer_assertions_i (
    .packet_in     (packet_in),
    .arst_n        (arst_n),
    .cfg_req_valid (cfg_req_valid),
    .cfg_ack       (cfg_ack),
    .pkt_tx_valid  (pkt_tx_valid),
    .pkt_tx_ready  (pkt_tx_ready),
    .pkt_tx_data   (pkt_tx_data)
);

/* tb_ingress_policer.sv */
/* Ingress policer testbench, driven from the cases file, with
   random back-pressure, an output scoreboard and a watchdog */
module tb_ingress_policer
    import policer_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS = 4;
    localparam int CLK_PERIOD = 4;
    localparam int CYCLES_PER_CASE = 200;
    localparam logic [31:0] SEED = 32'hf15a_82f5;
    // Port 2 stays disabled for the whole run
    localparam logic [NUM_PORTS-1:0] PORT_ENABLE = 4'b1011;

    logic      packet_in;
    logic      arst_n;
    logic      pkt_rx_valid;
    pkt_beat_t pkt_rx_data;
    logic      pkt_rx_ready;
    logic      pkt_tx_valid;
    pkt_beat_t pkt_tx_data;
    logic      pkt_tx_ready;
    logic      cfg_req_valid;
    cfg_req_t  cfg_req;
    logic      cfg_ack;
    cfg_rsp_t  cfg_rsp;

    // Scoreboard, with the case number of each expected beat
    pkt_beat_t   exp_beats [$];
    int          exp_cases [$];
    int          num_cases = 0;
    logic        bp_on = 1'b0;
    // Separate generators for data and back-pressure
    logic [31:0] data_seed = ~SEED;
    logic [31:0] bp_seed = SEED;

    ingress_policer_top #(
        .NUM_PORTS (NUM_PORTS)
    ) ingress_policer_top_i (
        .packet_in     (packet_in),
        .arst_n        (arst_n),
        .enable        (PORT_ENABLE),
        .pkt_rx_valid  (pkt_rx_valid),
        .pkt_rx_data   (pkt_rx_data),
        .pkt_rx_ready  (pkt_rx_ready),
        .pkt_tx_valid  (pkt_tx_valid),
        .pkt_tx_data   (pkt_tx_data),
        .pkt_tx_ready  (pkt_tx_ready),
        .cfg_req_valid (cfg_req_valid),
        .cfg_req       (cfg_req),
        .cfg_ack       (cfg_ack),
        .cfg_rsp       (cfg_rsp)
    );

    ////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error: %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    // Four-phase access, response checked while ack is high
    task automatic cfg_access(input int case_no, input logic wr, input logic tbl,
                              input logic [5:0] port, input logic [35:0] wdata,
                              input logic exp_err, input logic [35:0] exp_rdata);
        @(negedge packet_in);
        cfg_req = '{write: wr, table_sel: policer_table_e'(tbl), port: port, wdata: wdata};
        cfg_req_valid = 1'b1;
        @(negedge packet_in);
        while (!cfg_ack) @(negedge packet_in);
        check_value($sformatf("case %0d cfg error", case_no), exp_err, cfg_rsp.error);
        check_value($sformatf("case %0d cfg rdata", case_no), exp_rdata, cfg_rsp.rdata);
        cfg_req_valid = 1'b0;
        @(negedge packet_in);
        while (cfg_ack) @(negedge packet_in);
    endtask

    // One packet, every beat queued with the expected mark
    task automatic send_packet(input int case_no, input logic [PORT_ID_BITS-1:0] port,
                               input int len, input int beats, input logic mark);
        pkt_beat_t beat;
        int        tail;
        // Valid bytes in the last beat
        tail = (len % DATA_BYTES == 0) ? DATA_BYTES : len % DATA_BYTES;
        for (int b = 0; b < beats; b++) begin
            data_seed = lcg_step(data_seed);
            beat.data = {data_seed, ~data_seed};
            beat.last = (b == beats - 1);
            beat.keep = beat.last ? DATA_BYTES'((1 << tail) - 1) : '1;
            beat.meta = '{ingress_port: port, byte_length: len[15:0], drop_mark: 1'b0};
            @(negedge packet_in);
            pkt_rx_valid = 1'b1;
            pkt_rx_data = beat;
            beat.meta.drop_mark = mark;
            exp_beats.push_back(beat);
            exp_cases.push_back(case_no);
            // Ready sampled mid-low, taken at the next rising edge
            #1;
            while (!pkt_rx_ready) begin
                @(negedge packet_in);
                #1;
            end
        end
        @(negedge packet_in);
        pkt_rx_valid = 1'b0;
    endtask

    ////////////////////////////////////////
    // Clock, watchdog, back-pressure and scoreboard

    initial begin
        packet_in = 1'b0;
        forever #(CLK_PERIOD / 2) packet_in = ~packet_in;
    end

    initial begin
        wait (num_cases > 0);
        #((num_cases + 4) * CYCLES_PER_CASE * CLK_PERIOD);
        stop_with_failure($sformatf("Watchdog expired, %0d cases did not finish in time",
                                    num_cases));
    end

    initial begin
        pkt_beat_t expected;
        int        case_no;
        pkt_tx_ready = 1'b1;
        forever begin
            @(negedge packet_in);
            bp_seed = lcg_step(bp_seed);
            // Roughly half the cycles stalled
            pkt_tx_ready = !bp_on || bp_seed[20];
            #1;
            if (pkt_tx_valid && pkt_tx_ready) begin
                if (exp_beats.size() == 0) begin
                    stop_with_failure("Output beat seen with no beat outstanding");
                end
                expected = exp_beats.pop_front();
                case_no = exp_cases.pop_front();
                check_value($sformatf("case %0d output beat", case_no), expected, pkt_tx_data);
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence

    initial begin
        int            fd;
        int            code;
        int            count;
        int            case_no;
        logic [63:0]   cmd;
        logic [1023:0] rest;
        logic          wr;
        logic          tbl;
        logic [5:0]    port;
        logic [35:0]   wdata;
        logic          exp_err;
        logic [35:0]   exp_rdata;
        int            len;
        int            beats;
        int            mark;

        arst_n        = 1'b0;
        pkt_rx_valid  = 1'b0;
        pkt_rx_data   = '0;
        cfg_req_valid = 1'b0;
        cfg_req       = '0;

        // Count pass sizes the watchdog
        count = 0;
        fd = $fopen("ingress_policer_cases.txt", "r");
        if (fd == 0) stop_with_failure("Cannot open ingress_policer_cases.txt");
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd != "#") count++;
            code = $fgets(rest, fd);
        end
        $fclose(fd);
        if (count == 0) stop_with_failure("The cases file holds no cases");
        num_cases = count;

        repeat (3) @(posedge packet_in);
        @(negedge packet_in);
        arst_n = 1'b1;
        #1;
        check_value("reset pkt_tx_valid", 0, pkt_tx_valid);
        check_value("reset cfg_ack", 0, cfg_ack);
        check_value("reset pkt_rx_ready", 1, pkt_rx_ready);

        case_no = 0;
        fd = $fopen("ingress_policer_cases.txt", "r");
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd != "#") case_no++;
            if (cmd == "cfg") begin
                code = $fscanf(fd, "%h %h %h %h %h %h", wr, tbl, port, wdata, exp_err, exp_rdata);
                if (code != 6) stop_with_failure($sformatf("Bad cfg line, case %0d", case_no));
                cfg_access(case_no, wr, tbl, port, wdata, exp_err, exp_rdata);
            end else if (cmd == "pkt") begin
                code = $fscanf(fd, "%d %d %d %d", port, len, beats, mark);
                if (code != 4) stop_with_failure($sformatf("Bad pkt line, case %0d", case_no));
                send_packet(case_no, port[PORT_ID_BITS-1:0], len, beats, mark[0]);
            end else if (cmd == "bp") begin
                code = $fscanf(fd, "%d", mark);
                if (code != 1) stop_with_failure($sformatf("Bad bp line, case %0d", case_no));
                bp_on = mark[0];
            end else if (cmd != "#") begin
                stop_with_failure($sformatf("Unknown command in case %0d", case_no));
            end
            code = $fgets(rest, fd);
        end
        $fclose(fd);

        // Let the last beats drain through the stage
        while (exp_beats.size() != 0) @(negedge packet_in);
        repeat (4) @(negedge packet_in);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* ingress_policer_cases.txt */
# cfg write table port wdata err rdata (hex, table 0 CIR 1 CBS), pkt port length beats mark
# bp on (decimal), back-pressure switch
# reset contents
cfg 0 0 00 000000000 0 fffffffff
cfg 0 1 00 000000000 0 0000fffff
cfg 0 0 03 000000000 0 fffffffff
cfg 0 1 03 000000000 0 0000fffff
# table write and read back
cfg 1 0 00 000000000 0 000000000
cfg 1 1 00 0000000c8 0 000000000
cfg 0 0 00 000000000 0 000000000
cfg 0 1 00 000000000 0 0000000c8
cfg 1 0 01 000018000 0 000000000
cfg 1 1 01 000000400 0 000000000
cfg 0 0 01 000000000 0 000018000
cfg 0 1 01 000000000 0 000000400
# out of range, table unchanged
cfg 1 0 05 123456789 1 000000000
cfg 1 1 3f 0000000ff 1 000000000
cfg 0 0 05 000000000 1 000000000
cfg 0 0 01 000000000 0 000018000
cfg 1 0 02 000000000 0 000000000
cfg 1 1 02 00000000a 0 000000000
cfg 1 1 03 000000064 0 000000000
cfg 0 0 03 000000000 0 fffffffff
# port 0 no drain depth 200, port 2 disabled, port 3 full drain depth 100
pkt 0 64 3 0
pkt 0 100 2 0
pkt 2 500 4 0
pkt 3 100 1 0
pkt 3 101 2 1
bp 1
pkt 0 36 1 0
pkt 2 1500 3 0
pkt 3 40 2 0
pkt 0 1 1 1
pkt 3 100 4 0
pkt 1 16 2 0
pkt 1 2000 3 1
pkt 0 10 2 1
pkt 3 2000 3 1
pkt 2 9999 1 0
pkt 0 200 4 1
bp 0
pkt 0 5 1 1
pkt 3 64 1 0
cfg 0 1 00 000000000 0 0000000c8

/* ingress_policer.f */
policer_pkg.sv
policer_config.sv
bucket_array.sv
policer_stage.sv
ingress_policer_top.sv
ingress_policer_assertions.sv
tb_ingress_policer.sv

/* Makefile */
# Verilator build and run of the ingress policer testbench

VERILATOR ?= verilator
TOP       ?= tb_ingress_policer
FILELIST  ?= ingress_policer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)
	@echo "Test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
